//--- tb.f
+incdir+bench
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_control.sv
rtl/rv_core.sv
bench/core_properties.sv
bench/tb_core.sv

//--- bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int    PROG_WORDS = 50;
localparam word_t ECALL_ADDR = 32'h0000_00c4;

task load_program();
   // x10 holds the data base, x1 = 0x35 and x2 = -16
   mem[0]  = 32'h1000_0513;   // 0x00 addi x10, x0, 256
   mem[1]  = 32'h0350_0093;   // 0x04 addi x1, x0, 0x35
   mem[2]  = 32'hff00_0113;   // 0x08 addi x2, x0, -16
   // One store per ALU result
   mem[3]  = 32'h0020_81b3;   // 0x0c add  x3, x1, x2
   mem[4]  = 32'h0035_2023;   // 0x10 sw   x3, 0(x10)
   mem[5]  = 32'h4020_81b3;   // 0x14 sub  x3, x1, x2
   mem[6]  = 32'h0035_2223;   // 0x18 sw   x3, 4(x10)
   mem[7]  = 32'h0020_f1b3;   // 0x1c and  x3, x1, x2
   mem[8]  = 32'h0035_2423;   // 0x20 sw   x3, 8(x10)
   mem[9]  = 32'h0020_e1b3;   // 0x24 or   x3, x1, x2
   mem[10] = 32'h0035_2623;   // 0x28 sw   x3, 12(x10)
   mem[11] = 32'h0020_c1b3;   // 0x2c xor  x3, x1, x2
   mem[12] = 32'h0035_2823;   // 0x30 sw   x3, 16(x10)
   mem[13] = 32'h0020_a1b3;   // 0x34 slt  x3, x1, x2
   mem[14] = 32'h0035_2a23;   // 0x38 sw   x3, 20(x10)
   mem[15] = 32'h0020_b1b3;   // 0x3c sltu x3, x1, x2
   mem[16] = 32'h0035_2c23;   // 0x40 sw   x3, 24(x10)
   mem[17] = 32'h0040_9193;   // 0x44 slli x3, x1, 4
   mem[18] = 32'h0035_2e23;   // 0x48 sw   x3, 28(x10)
   mem[19] = 32'h0011_51b3;   // 0x4c srl  x3, x2, x1
   mem[20] = 32'h0235_2023;   // 0x50 sw   x3, 32(x10)
   mem[21] = 32'h4021_5193;   // 0x54 srai x3, x2, 2
   mem[22] = 32'h0235_2223;   // 0x58 sw   x3, 36(x10)
   mem[23] = 32'h1234_51b7;   // 0x5c lui  x3, 0x12345
   mem[24] = 32'h0235_2423;   // 0x60 sw   x3, 40(x10)
   mem[25] = 32'h0000_1197;   // 0x64 auipc x3, 0x1
   mem[26] = 32'h0235_2623;   // 0x68 sw   x3, 44(x10)
   // Stores to 124(x10) must never happen
   mem[27] = 32'h0020_9463;   // 0x6c bne  x1, x2, +8 (taken)
   mem[28] = 32'h0615_2e23;   // 0x70 sw   x1, 124(x10)
   mem[29] = 32'h0020_8463;   // 0x74 beq  x1, x2, +8 (not taken)
   mem[30] = 32'h0215_2823;   // 0x78 sw   x1, 48(x10)
   mem[31] = 32'h0011_4463;   // 0x7c blt  x2, x1, +8 (taken)
   mem[32] = 32'h0615_2e23;   // 0x80 sw   x1, 124(x10)
   mem[33] = 32'h0011_6463;   // 0x84 bltu x2, x1, +8 (not taken)
   mem[34] = 32'h0215_2a23;   // 0x88 sw   x1, 52(x10)
   mem[35] = 32'h0020_d463;   // 0x8c bge  x1, x2, +8 (taken)
   mem[36] = 32'h0615_2e23;   // 0x90 sw   x1, 124(x10)
   mem[37] = 32'h0020_f463;   // 0x94 bgeu x1, x2, +8 (not taken)
   mem[38] = 32'h0215_2c23;   // 0x98 sw   x1, 56(x10)
   // Jumps with link values
   mem[39] = 32'h0080_02ef;   // 0x9c jal  x5, +8
   mem[40] = 32'h0615_2e23;   // 0xa0 sw   x1, 124(x10)
   mem[41] = 32'h0255_2e23;   // 0xa4 sw   x5, 60(x10)
   mem[42] = 32'h0112_8367;   // 0xa8 jalr x6, 17(x5) to odd target 0xb1
   mem[43] = 32'h0615_2e23;   // 0xac sw   x1, 124(x10)
   mem[44] = 32'h0465_2023;   // 0xb0 sw   x6, 64(x10)
   // Round trip through memory and the x0 write
   mem[45] = 32'h0285_2383;   // 0xb4 lw   x7, 40(x10)
   mem[46] = 32'h0475_2223;   // 0xb8 sw   x7, 68(x10)
   mem[47] = 32'h0550_0013;   // 0xbc addi x0, x0, 0x55
   mem[48] = 32'h0405_2423;   // 0xc0 sw   x0, 72(x10)
   mem[49] = 32'h0000_0073;   // 0xc4 ecall
endtask

`endif

//--- bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
   import rv_pkg::*;

   localparam int MEM_WORDS  = 128;
   localparam int NUM_TESTS  = 6;
   localparam int HALT_WATCH = 10;

   logic       clk;
   logic       reset;
   logic       ack;
   word_t      rdata;
   logic       cyc;
   logic       stb;
   logic       we;
   word_t      adr;
   word_t      wdata;
   logic [3:0] sel;
   word_t      pc;
   logic       halted;

   word_t  mem [MEM_WORDS];
   integer seed;
   int     wait_left;
   logic   busy;
   int     cycle_count;
   int     cycle_limit;
   int     stray_count;
   int     test_errors [1:NUM_TESTS];
   string  test_name [1:NUM_TESTS];
   word_t  got_addr [$];
   word_t  got_data [$];
   word_t  exp_addr [$];
   word_t  exp_data [$];
   int     exp_test [$];

`include "tb_program.svh"

   rv_core #(
      .RESET_VECTOR (32'h0000_0000)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .ack_i    (ack),
      .dat_i    (rdata),
      .cyc_o    (cyc),
      .stb_o    (stb),
      .we_o     (we),
      .adr_o    (adr),
      .dat_o    (wdata),
      .sel_o    (sel),
      .pc_o     (pc),
      .halted_o (halted)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // ==================================================
   // Bus memory model
   // ==================================================
   task serve_request();
      int index;
      index = int'(adr[8:2]);
      check_value(5, "byte selects", word_t'(sel), 32'h0000_000f);
      if (we) begin
         got_addr.push_back(adr);
         got_data.push_back(wdata);
      end
      if (adr >= 4 * MEM_WORDS) begin
         stray_count++;
      end else if (we) begin
         mem[index] = wdata;
      end else begin
         rdata = mem[index];
      end
   endtask

   // One-cycle ack after 0 to 2 wait cycles
   always @(posedge clk) begin
      #1;
      if (reset || ack) begin
         ack  = 1'b0;
         busy = 1'b0;
      end else if (cyc && stb) begin
         if (!busy) begin
            busy      = 1'b1;
            wait_left = {$random(seed)} % 3;
         end
         if (wait_left > 0) begin
            wait_left = wait_left - 1;
         end else begin
            serve_request();
            ack = 1'b1;
         end
      end
   end

   // ==================================================
   // Expected stores and checks
   // ==================================================
   task add_expected(input int test, input word_t addr, input word_t data);
      exp_test.push_back(test);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // x1 = 0x35, x2 = 0xfffffff0
   task fill_expected();
      add_expected(1, 32'h0000_0100, 32'h0000_0025);   // add
      add_expected(1, 32'h0000_0104, 32'h0000_0045);   // sub
      add_expected(1, 32'h0000_0108, 32'h0000_0030);   // and
      add_expected(1, 32'h0000_010c, 32'hffff_fff5);   // or
      add_expected(1, 32'h0000_0110, 32'hffff_ffc5);   // xor
      add_expected(1, 32'h0000_0114, 32'h0000_0000);   // slt with signed 53 < -16 false
      add_expected(1, 32'h0000_0118, 32'h0000_0001);   // sltu
      add_expected(1, 32'h0000_011c, 32'h0000_0350);   // slli by 4
      add_expected(1, 32'h0000_0120, 32'h0000_07ff);   // srl by 21
      add_expected(1, 32'h0000_0124, 32'hffff_fffc);   // srai by 2
      add_expected(1, 32'h0000_0128, 32'h1234_5000);   // lui
      add_expected(1, 32'h0000_012c, 32'h0000_1064);   // auipc at 0x64
      add_expected(2, 32'h0000_0130, 32'h0000_0035);   // after beq fall through
      add_expected(2, 32'h0000_0134, 32'h0000_0035);   // after bltu fall through
      add_expected(2, 32'h0000_0138, 32'h0000_0035);   // after bgeu fall through
      add_expected(2, 32'h0000_013c, 32'h0000_00a0);   // jal link
      add_expected(2, 32'h0000_0140, 32'h0000_00ac);   // jalr link
      add_expected(3, 32'h0000_0144, 32'h1234_5000);   // reloaded lui value
      add_expected(4, 32'h0000_0148, 32'h0000_0000);   // x0
   endtask

   task automatic check_value(input int test, input string what,
                              input word_t got, input word_t expected);
      if (got !== expected) begin
         $display("FAILED at %0t ns: test %0d, %s: got %h, expected %h",
                  $time, test, what, got, expected);
         test_errors[test]++;
      end
   endtask

   task report_test(input int test);
      if (test_errors[test] == 0) begin
         $display("Test %0d, %s: passed", test, test_name[test]);
      end else begin
         $display("Test %0d, %s: failed with %0d errors", test, test_name[test],
                  test_errors[test]);
      end
   endtask

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      int i;
      int failed_tests;

      seed         = 32'h09e66ca1;
      reset        = 1'b1;
      ack          = 1'b0;
      rdata        = '0;
      busy         = 1'b0;
      wait_left    = 0;
      cycle_count  = 0;
      stray_count  = 0;
      failed_tests = 0;
      test_name[1] = "ALU and immediate results";
      test_name[2] = "branches, JAL and JALR";
      test_name[3] = "store, load and store again";
      test_name[4] = "x0 stays zero";
      test_name[5] = "store order under random ack delays";
      test_name[6] = "halt on ECALL";
      for (i = 1; i <= NUM_TESTS; i++) begin
         test_errors[i] = 0;
      end
      // Fill depends on the full byte address
      for (i = 0; i < MEM_WORDS; i++) begin
         mem[i] = ~(word_t'(i) << 2);
      end
      load_program();
      fill_expected();
      cycle_limit = 40 * PROG_WORDS;

      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      while (!halted && cycle_count < cycle_limit) begin
         @(posedge clk);
         #1;
      end

      if (!halted) begin
         $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
         $display("Some tests failed");
      end else begin
         for (i = 0; i < exp_addr.size(); i++) begin
            if (i < got_addr.size()) begin
               check_value(exp_test[i], $sformatf("store %0d address", i),
                           got_addr[i], exp_addr[i]);
               check_value(exp_test[i], $sformatf("store %0d data", i),
                           got_data[i], exp_data[i]);
            end else begin
               $display("Store %0d to address %h never happened", i, exp_addr[i]);
               test_errors[exp_test[i]]++;
            end
         end
         for (i = 1; i <= 4; i++) begin
            report_test(i);
         end

         check_value(5, "store count", got_addr.size(), exp_addr.size());
         check_value(5, "accesses outside memory", stray_count, 0);
         if (test_errors[1] + test_errors[2] + test_errors[3] + test_errors[4] != 0) begin
            $display("The stored sequence differs from the expected table");
            test_errors[5]++;
         end
         report_test(5);

         check_value(6, "pc at halt", pc, ECALL_ADDR);
         repeat (HALT_WATCH) begin
            @(posedge clk);
            #1;
            check_value(6, "halted_o after halt", word_t'(halted), 32'd1);
            check_value(6, "bus request after halt", word_t'(cyc || stb), 32'd0);
         end
         report_test(6);

         for (i = 1; i <= NUM_TESTS; i++) begin
            if (test_errors[i] != 0) begin
               failed_tests++;
            end
         end
         $display("%0d of %0d tests ok, %0d failed, %0d cycles",
                  NUM_TESTS - failed_tests, NUM_TESTS, failed_tests, cycle_count);
         if (failed_tests == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module core_properties (
   input wire                clk,
   input wire                reset,
   input wire                cyc_i,
   input wire                stb_i,
   input wire                we_i,
   input wire                ack_i,
   input wire rv_pkg::word_t adr_i,
   input wire                halted_i
);

   stb_inside_cyc: assert property (@(posedge clk) disable iff (reset) stb_i |-> cyc_i)
      else $error("stb_o seen without cyc_o");

   // Waiting request keeps its address
   request_held: assert property (@(posedge clk) disable iff (reset)
      (stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
      else $error("request changed before ack_i");

   we_inside_stb: assert property (@(posedge clk) disable iff (reset) we_i |-> stb_i)
      else $error("we_o seen without stb_o");

   quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
      halted_i |=> (halted_i && !stb_i))
      else $error("bus request or halt drop after halted_o");

endmodule

bind rv_core core_properties u_properties (
   .clk      (clk),
   .reset    (reset),
   .cyc_i    (cyc_o),
   .stb_i    (stb_o),
   .we_i     (we_o),
   .ack_i    (ack_i),
   .adr_i    (adr_o),
   .halted_i (halted_o)
);

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
   parameter rv_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
   input  wire                clk,
   input  wire                reset,
   input  wire                ack_i,
   input  wire rv_pkg::word_t dat_i,
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output rv_pkg::word_t      adr_o,
   output rv_pkg::word_t      dat_o,
   output logic [3:0]         sel_o,
   output rv_pkg::word_t      pc_o,
   output logic               halted_o
);
   import rv_pkg::*;

   word_t      instr;
   reg_addr_t  rs1;
   reg_addr_t  rs2;
   reg_addr_t  rd;
   word_t      imm;
   logic [2:0] funct3;
   insn_kind_t kind;
   alu_op_t    alu_op;
   logic       uses_imm;
   logic       uses_pc;
   logic       writes_rd;
   word_t      rs1_val;
   word_t      rs2_val;
   word_t      alu_result;
   logic       branch_taken;
   logic       branch_pass;
   logic       reg_we;
   word_t      reg_wdata;

   rv_control #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_control (
      .clk            (clk),
      .reset          (reset),
      .ack_i          (ack_i),
      .dat_i          (dat_i),
      .kind_i         (kind),
      .writes_rd_i    (writes_rd),
      .alu_result_i   (alu_result),
      .branch_taken_i (branch_taken),
      .rs2_val_i      (rs2_val),
      .cyc_o          (cyc_o),
      .stb_o          (stb_o),
      .we_o           (we_o),
      .adr_o          (adr_o),
      .dat_o          (dat_o),
      .sel_o          (sel_o),
      .instr_o        (instr),
      .pc_o           (pc_o),
      .reg_we_o       (reg_we),
      .reg_wdata_o    (reg_wdata),
      .branch_pass_o  (branch_pass),
      .halted_o       (halted_o)
   );

   rv_decode u_decode (
      .instr_i     (instr),
      .rs1_o       (rs1),
      .rs2_o       (rs2),
      .rd_o        (rd),
      .imm_o       (imm),
      .funct3_o    (funct3),
      .kind_o      (kind),
      .alu_op_o    (alu_op),
      .uses_imm_o  (uses_imm),
      .uses_pc_o   (uses_pc),
      .writes_rd_o (writes_rd)
   );

   rv_execute u_execute (
      .rs1_val_i      (rs1_val),
      .rs2_val_i      (rs2_val),
      .imm_i          (imm),
      .pc_i           (pc_o),
      .alu_op_i       (alu_op),
      .uses_imm_i     (uses_imm),
      .uses_pc_i      (uses_pc),
      .kind_i         (kind),
      .funct3_i       (funct3),
      .branch_pass_i  (branch_pass),
      .alu_result_o   (alu_result),
      .branch_taken_o (branch_taken)
   );

   rv_result u_result (
      .clk       (clk),
      .reset     (reset),
      .rs1_i     (rs1),
      .rs2_i     (rs2),
      .rd_i      (rd),
      .we_i      (reg_we),
      .wdata_i   (reg_wdata),
      .rs1_val_o (rs1_val),
      .rs2_val_o (rs2_val)
   );

endmodule

`default_nettype wire

//--- rtl/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control #(
   parameter rv_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     ack_i,
   input  wire rv_pkg::word_t      dat_i,
   input  wire rv_pkg::insn_kind_t kind_i,
   input  wire                     writes_rd_i,
   input  wire rv_pkg::word_t      alu_result_i,
   input  wire                     branch_taken_i,
   input  wire rv_pkg::word_t      rs2_val_i,
   output logic                    cyc_o,
   output logic                    stb_o,
   output logic                    we_o,
   output rv_pkg::word_t           adr_o,
   output rv_pkg::word_t           dat_o,
   output logic [3:0]              sel_o,
   output rv_pkg::word_t           instr_o,
   output rv_pkg::word_t           pc_o,
   output logic                    reg_we_o,
   output rv_pkg::word_t           reg_wdata_o,
   output logic                    branch_pass_o,
   output logic                    halted_o
);
   import rv_pkg::*;

   typedef enum logic [2:0] {
      S_RESET,
      S_FETCH,
      S_EXEC,
      S_MEM,
      S_WRITE,
      S_HALT
   } state_t;

   state_t  state;
   state_t  next_state;
   word_t   pc;
   word_t   pc_plus;
   word_t   instr;
   word_t   alu_q;
   word_t   load_q;
   logic    branch_pass;
   logic    taken_q;
   logic    redirect;
   wb_src_t wb_src;

   assign pc_plus = pc + INSN_BYTES;

   // ==================================================
   // Sequencer
   // ==================================================
   always_comb begin
      next_state = state;
      case (state)
         S_RESET: next_state = S_FETCH;
         S_FETCH: begin
            if (ack_i) begin
               next_state = S_EXEC;
            end
         end
         S_EXEC: begin
            if (kind_i == KIND_HALT) begin
               next_state = S_HALT;
            end else if (kind_i == KIND_LOAD || kind_i == KIND_STORE) begin
               next_state = S_MEM;
            end else if (kind_i == KIND_BRANCH && !branch_pass) begin
               // Second pass computes the target
               next_state = S_EXEC;
            end else begin
               next_state = S_WRITE;
            end
         end
         S_MEM: begin
            if (ack_i) begin
               next_state = S_WRITE;
            end
         end
         S_WRITE: next_state = S_FETCH;
         default: next_state = S_HALT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= S_RESET;
         pc          <= RESET_VECTOR;
         branch_pass <= 1'b0;
         taken_q     <= 1'b0;
      end else begin
         state <= next_state;
         if (state == S_EXEC) begin
            branch_pass <= (kind_i == KIND_BRANCH) && !branch_pass;
            if (!branch_pass) begin
               taken_q <= branch_taken_i;
            end
         end
         if (state == S_WRITE) begin
            pc <= redirect ? (alu_q & ~32'h1) : pc_plus;
         end
      end
   end

   // Instruction, ALU result and load data
   always_ff @(posedge clk) begin
      if (state == S_FETCH && ack_i) begin
         instr <= dat_i;
      end
      if (state == S_EXEC) begin
         alu_q <= alu_result_i;
      end
      if (state == S_MEM && ack_i) begin
         load_q <= dat_i;
      end
   end

   // ==================================================
   // Write back and next pc
   // ==================================================
   assign redirect = (kind_i == KIND_JAL) || (kind_i == KIND_JALR) ||
                     (kind_i == KIND_BRANCH && taken_q);

   always_comb begin
      case (kind_i)
         KIND_LOAD:           wb_src = WB_LOAD;
         KIND_JAL, KIND_JALR: wb_src = WB_LINK;
         default:             wb_src = WB_ALU;
      endcase
   end

   always_comb begin
      case (wb_src)
         WB_LOAD: reg_wdata_o = load_q;
         WB_LINK: reg_wdata_o = pc_plus;
         default: reg_wdata_o = alu_q;
      endcase
   end

   assign reg_we_o = (state == S_WRITE) && writes_rd_i;

   // Bus master, word accesses only
   assign cyc_o = (state == S_FETCH) || (state == S_MEM);
   assign stb_o = cyc_o;
   assign we_o  = (state == S_MEM) && (kind_i == KIND_STORE);
   assign adr_o = (state == S_MEM) ? alu_q : pc;
   assign dat_o = rs2_val_i;
   assign sel_o = 4'hf;

   assign instr_o       = instr;
   assign pc_o          = pc;
   assign branch_pass_o = branch_pass;
   assign halted_o      = (state == S_HALT);

endmodule

`default_nettype wire

//--- rtl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
   input  wire                    clk,
   input  wire                    reset,
   input  wire rv_pkg::reg_addr_t rs1_i,
   input  wire rv_pkg::reg_addr_t rs2_i,
   input  wire rv_pkg::reg_addr_t rd_i,
   input  wire                    we_i,
   input  wire rv_pkg::word_t     wdata_i,
   output rv_pkg::word_t          rs1_val_o,
   output rv_pkg::word_t          rs2_val_o
);
   import rv_pkg::*;

   // x1..x31, x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
   input  wire rv_pkg::word_t      rs1_val_i,
   input  wire rv_pkg::word_t      rs2_val_i,
   input  wire rv_pkg::word_t      imm_i,
   input  wire rv_pkg::word_t      pc_i,
   input  wire rv_pkg::alu_op_t    alu_op_i,
   input  wire                     uses_imm_i,
   input  wire                     uses_pc_i,
   input  wire rv_pkg::insn_kind_t kind_i,
   input  wire [2:0]               funct3_i,
   input  wire                     branch_pass_i,
   output rv_pkg::word_t           alu_result_o,
   output logic                    branch_taken_o
);
   import rv_pkg::*;

   word_t      op_a;
   word_t      op_b;
   alu_op_t    op;
   logic [4:0] shamt;
   logic       eq;
   logic       lt;
   logic       ltu;
   logic       cond;

   // Branch target pass forces pc + imm
   assign op_a  = (uses_pc_i || branch_pass_i) ? pc_i : rs1_val_i;
   assign op_b  = (uses_imm_i || branch_pass_i) ? imm_i : rs2_val_i;
   assign op    = branch_pass_i ? ALU_ADD : alu_op_i;
   assign shamt = op_b[4:0];

   always_comb begin
      case (op)
         ALU_ADD:    alu_result_o = op_a + op_b;
         ALU_SUB:    alu_result_o = op_a - op_b;
         ALU_AND:    alu_result_o = op_a & op_b;
         ALU_OR:     alu_result_o = op_a | op_b;
         ALU_XOR:    alu_result_o = op_a ^ op_b;
         ALU_SLT:    alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:   alu_result_o = {31'b0, op_a < op_b};
         ALU_SLL:    alu_result_o = op_a << shamt;
         ALU_SRL:    alu_result_o = op_a >> shamt;
         ALU_SRA:    alu_result_o = $unsigned($signed(op_a) >>> shamt);
         ALU_PASS_B: alu_result_o = op_b;
         default:    alu_result_o = op_a + op_b;
      endcase
   end

   // Compare registers directly
   assign eq  = (rs1_val_i == rs2_val_i);
   assign lt  = ($signed(rs1_val_i) < $signed(rs2_val_i));
   assign ltu = (rs1_val_i < rs2_val_i);

   always_comb begin
      case (funct3_i)
         F3_BEQ:  cond = eq;
         F3_BNE:  cond = !eq;
         F3_BLT:  cond = lt;
         F3_BGE:  cond = !lt;
         F3_BLTU: cond = ltu;
         F3_BGEU: cond = !ltu;
         default: cond = 1'b0;
      endcase
   end

   assign branch_taken_o = (kind_i == KIND_BRANCH) && cond;

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
   input  wire rv_pkg::word_t  instr_i,
   output rv_pkg::reg_addr_t   rs1_o,
   output rv_pkg::reg_addr_t   rs2_o,
   output rv_pkg::reg_addr_t   rd_o,
   output rv_pkg::word_t       imm_o,
   output logic [2:0]          funct3_o,
   output rv_pkg::insn_kind_t  kind_o,
   output rv_pkg::alu_op_t     alu_op_o,
   output logic                uses_imm_o,
   output logic                uses_pc_o,
   output logic                writes_rd_o
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [6:0] funct7;
   logic [2:0] funct3;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   logic       op_ok;
   logic       imm_ok;
   alu_op_t    f3_op;

   assign opcode   = instr_i[6:0];
   assign funct3   = instr_i[14:12];
   assign funct7   = instr_i[31:25];
   assign rd_o     = instr_i[11:7];
   assign rs1_o    = instr_i[19:15];
   assign rs2_o    = instr_i[24:20];
   assign funct3_o = funct3;

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   // Only SUB and SRA/SRAI may set funct7 bit 30
   assign op_ok  = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
   assign imm_ok = (funct3[1:0] != 2'b01) || (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && funct3 == 3'b101);

   always_comb begin
      case (funct3)
         3'b000:  f3_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
         3'b001:  f3_op = ALU_SLL;
         3'b010:  f3_op = ALU_SLT;
         3'b011:  f3_op = ALU_SLTU;
         3'b100:  f3_op = ALU_XOR;
         3'b101:  f3_op = instr_i[30] ? ALU_SRA : ALU_SRL;
         3'b110:  f3_op = ALU_OR;
         default: f3_op = ALU_AND;
      endcase
   end

   // Anything not matched below halts the core
   always_comb begin
      kind_o      = KIND_HALT;
      alu_op_o    = ALU_ADD;
      imm_o       = imm_i;
      uses_imm_o  = 1'b1;
      uses_pc_o   = 1'b0;
      writes_rd_o = 1'b0;
      case (opcode)
         OPC_OP: begin
            if (op_ok) begin
               kind_o      = KIND_ALU;
               alu_op_o    = f3_op;
               uses_imm_o  = 1'b0;
               writes_rd_o = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            if (imm_ok) begin
               kind_o      = KIND_ALU;
               alu_op_o    = f3_op;
               writes_rd_o = 1'b1;
            end
         end
         OPC_LUI: begin
            kind_o      = KIND_ALU;
            alu_op_o    = ALU_PASS_B;
            imm_o       = imm_u;
            writes_rd_o = 1'b1;
         end
         OPC_AUIPC: begin
            kind_o      = KIND_ALU;
            imm_o       = imm_u;
            uses_pc_o   = 1'b1;
            writes_rd_o = 1'b1;
         end
         OPC_JAL: begin
            kind_o      = KIND_JAL;
            imm_o       = imm_j;
            uses_pc_o   = 1'b1;
            writes_rd_o = 1'b1;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) begin
               kind_o      = KIND_JALR;
               writes_rd_o = 1'b1;
            end
         end
         OPC_BRANCH: begin
            // First pass reads both registers, the target pass uses pc and imm
            if (funct3[2:1] != 2'b01) begin
               kind_o     = KIND_BRANCH;
               imm_o      = imm_b;
               uses_imm_o = 1'b0;
            end
         end
         OPC_LOAD: begin
            if (funct3 == F3_W) begin
               kind_o      = KIND_LOAD;
               writes_rd_o = 1'b1;
            end
         end
         OPC_STORE: begin
            if (funct3 == F3_W) begin
               kind_o = KIND_STORE;
               imm_o  = imm_s;
            end
         end
         default: kind_o = KIND_HALT;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [2:0]  insn_kind_t;
   typedef logic [1:0]  wb_src_t;

   localparam word_t INSN_BYTES = 32'd4;

   // ==================================================
   // Opcodes
   // ==================================================
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   // Branch conditions and access width
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;
   localparam logic [2:0] F3_W    = 3'b010;

   // ==================================================
   // ALU operations
   // ==================================================
   localparam alu_op_t ALU_ADD    = 4'd0;
   localparam alu_op_t ALU_SUB    = 4'd1;
   localparam alu_op_t ALU_AND    = 4'd2;
   localparam alu_op_t ALU_OR     = 4'd3;
   localparam alu_op_t ALU_XOR    = 4'd4;
   localparam alu_op_t ALU_SLT    = 4'd5;
   localparam alu_op_t ALU_SLTU   = 4'd6;
   localparam alu_op_t ALU_SLL    = 4'd7;
   localparam alu_op_t ALU_SRL    = 4'd8;
   localparam alu_op_t ALU_SRA    = 4'd9;
   localparam alu_op_t ALU_PASS_B = 4'd10;

   // Instruction classes
   localparam insn_kind_t KIND_ALU    = 3'd0;
   localparam insn_kind_t KIND_LOAD   = 3'd1;
   localparam insn_kind_t KIND_STORE  = 3'd2;
   localparam insn_kind_t KIND_BRANCH = 3'd3;
   localparam insn_kind_t KIND_JAL    = 3'd4;
   localparam insn_kind_t KIND_JALR   = 3'd5;
   localparam insn_kind_t KIND_HALT   = 3'd6;

   // Register write sources
   localparam wb_src_t WB_ALU  = 2'd0;
   localparam wb_src_t WB_LOAD = 2'd1;
   localparam wb_src_t WB_LINK = 2'd2;

endpackage

`default_nettype wire
